//--- Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f vlog.f -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- hdl/up_bus_master.sv
`timescale 1ns/1ps

module up_bus_master (
   input  logic             clk,
   input  logic             nRst,
   input  logic             start,
   input  up_pkg::mem_req_t mreq,
   output logic             done,
   output logic [7:0]       rd_data,
   output logic             req,
   input  logic             ack,
   output up_pkg::mem_req_t bus,
   input  logic [7:0]       rdata
);

   typedef enum logic [1:0] {
      B_IDLE,
      B_REQ,
      B_RELEASE,
      B_DONE
   } bstate_t;

   bstate_t state;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= B_IDLE;
         bus   <= '0;
      end else begin
         case (state)
            B_IDLE: begin
               if (start) begin
                  bus   <= mreq;   // Held until the next start
                  state <= B_REQ;
               end
            end
            B_REQ: begin
               if (ack) begin
                  state <= B_RELEASE;
               end
            end
            B_RELEASE: begin
               if (!ack) begin
                  state <= B_DONE;
               end
            end
            B_DONE: state <= B_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == B_REQ) && ack) begin
         rd_data <= rdata;
      end
   end

   assign req  = (state == B_REQ);
   assign done = (state == B_DONE);

endmodule

//--- hdl/up_control.sv
`timescale 1ns/1ps

module up_control (
   input  logic             clk,
   input  logic             nRst,
   input  up_pkg::opcode_t  ir,
   input  logic             z,
   output up_pkg::dp_ctrl_t ctrl,
   input  logic [7:0]       result,
   input  logic [7:0]       r0,
   output logic             start,
   output up_pkg::mem_req_t mreq,
   input  logic             done,
   output logic             halted
);

   typedef enum logic [3:0] {
      S_FETCH,
      S_FETCH_WAIT,
      S_DECODE,
      S_SWAP1,
      S_SWAP2,
      S_SWAP3,
      S_MEM_WAIT,
      S_STACK_ADJ,
      S_HALT
   } state_t;

   state_t          state;
   state_t          next_state;
   up_pkg::rb_sel_t swap_a;
   up_pkg::rb_sel_t swap_b;
   logic            swap_a_pc;

   // Datapath operation used while executing an opcode
   function automatic up_pkg::dp_op_t exec_op(input up_pkg::opcode_t op);
      case (op)
         up_pkg::OP_ADD:    return up_pkg::DP_ADD;
         up_pkg::OP_SUB:    return up_pkg::DP_SUB;
         up_pkg::OP_MUL:    return up_pkg::DP_MUL;
         up_pkg::OP_DIV:    return up_pkg::DP_DIV;
         up_pkg::OP_SWP01:  return up_pkg::DP_X01;
         up_pkg::OP_SWP12:  return up_pkg::DP_X12;
         up_pkg::OP_SWP23:  return up_pkg::DP_X23;
         up_pkg::OP_SWPPC2: return up_pkg::DP_XPC2;
         up_pkg::OP_LD:     return up_pkg::DP_R3;
         up_pkg::OP_ST:     return up_pkg::DP_R3;
         up_pkg::OP_INC:    return up_pkg::DP_INC;
         up_pkg::OP_NAND:   return up_pkg::DP_NAND;
         up_pkg::OP_PUSH:   return up_pkg::DP_SP;
         up_pkg::OP_POP:    return up_pkg::DP_SP1;
         up_pkg::OP_BEQZ:   return up_pkg::DP_PCINC;   // Skip
         default:           return up_pkg::DP_PASS;
      endcase
   endfunction

   // XOR swap writes a, then b, then a again
   always_comb begin
      swap_a    = up_pkg::SEL_O0;
      swap_b    = up_pkg::SEL_O1;
      swap_a_pc = 1'b0;
      case (ir)
         up_pkg::OP_SWP12: begin
            swap_a = up_pkg::SEL_O1;
            swap_b = up_pkg::SEL_O2;
         end
         up_pkg::OP_SWP23: begin
            swap_a = up_pkg::SEL_O2;
            swap_b = up_pkg::SEL_O3;
         end
         up_pkg::OP_SWPPC2: begin
            swap_a_pc = 1'b1;   // pc takes the a role
            swap_b    = up_pkg::SEL_O2;
         end
         default: ;
      endcase
   end

   always_comb begin
      next_state  = state;
      ctrl        = '0;
      ctrl.op     = up_pkg::DP_PASS;
      ctrl.rb_sel = up_pkg::SEL_I0;
      start       = 1'b0;
      mreq.addr   = result;
      mreq.wdata  = r0;
      mreq.we     = 1'b0;
      case (state)
         S_FETCH: begin
            ctrl.op    = up_pkg::DP_PCADDR;
            start      = 1'b1;
            next_state = S_FETCH_WAIT;
         end
         S_FETCH_WAIT: begin
            ctrl.op = up_pkg::DP_PCINC;
            if (done) begin
               ctrl.ir_we = 1'b1;
               ctrl.pc_we = 1'b1;
               next_state = S_DECODE;
            end
         end
         S_DECODE: begin
            ctrl.op    = exec_op(ir);
            next_state = S_FETCH;
            case (ir)
               up_pkg::OP_ADD, up_pkg::OP_SUB, up_pkg::OP_MUL, up_pkg::OP_DIV,
               up_pkg::OP_INC, up_pkg::OP_NAND: begin
                  ctrl.rb_sel = up_pkg::SEL_O0;
                  ctrl.rb_we  = 1'b1;
                  ctrl.z_we   = 1'b1;
               end
               up_pkg::OP_SWP01, up_pkg::OP_SWP12, up_pkg::OP_SWP23,
               up_pkg::OP_SWPPC2: begin
                  next_state = S_SWAP1;
               end
               up_pkg::OP_LD, up_pkg::OP_ST, up_pkg::OP_PUSH, up_pkg::OP_POP: begin
                  start      = 1'b1;
                  mreq.we    = (ir == up_pkg::OP_ST) || (ir == up_pkg::OP_PUSH);
                  next_state = S_MEM_WAIT;
               end
               up_pkg::OP_BEQZ: begin
                  ctrl.pc_we = z;
               end
               up_pkg::OP_HALT: begin
                  next_state = S_HALT;
               end
            endcase
         end
         S_SWAP1, S_SWAP3: begin
            ctrl.op     = exec_op(ir);
            ctrl.pc_we  = swap_a_pc;
            ctrl.rb_sel = swap_a;
            ctrl.rb_we  = !swap_a_pc;
            next_state  = (state == S_SWAP1) ? S_SWAP2 : S_FETCH;
         end
         S_SWAP2: begin
            ctrl.op     = exec_op(ir);
            ctrl.rb_sel = swap_b;
            ctrl.rb_we  = 1'b1;
            next_state  = S_SWAP3;
         end
         S_MEM_WAIT: begin
            if (done) begin
               ctrl.rb_we = (ir == up_pkg::OP_LD) || (ir == up_pkg::OP_POP);
               if ((ir == up_pkg::OP_PUSH) || (ir == up_pkg::OP_POP)) begin
                  next_state = S_STACK_ADJ;
               end else begin
                  next_state = S_FETCH;
               end
            end
         end
         S_STACK_ADJ: begin
            ctrl.op    = (ir == up_pkg::OP_PUSH) ? up_pkg::DP_SPDEC : up_pkg::DP_SPINC;
            ctrl.sp_we = 1'b1;
            next_state = S_FETCH;
         end
         S_HALT: ;   // Parked until reset
         default: next_state = S_FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= S_FETCH;
      end else begin
         state <= next_state;
      end
   end

   assign halted = (state == S_HALT);

endmodule

//--- hdl/up_datapath.sv
`timescale 1ns/1ps

module up_datapath #(
   parameter logic [7:0] SP_RESET = 8'hFF
) (
   input  logic             clk,
   input  logic             nRst,
   input  up_pkg::dp_ctrl_t ctrl,
   input  logic [7:0]       data_in,
   output logic [7:0]       result,
   output logic [7:0]       r0,
   output up_pkg::opcode_t  ir,
   output logic             z
);

   logic [7:0] r1;
   logic [7:0] r2;
   logic [7:0] r3;
   logic [7:0] sp;
   logic [7:0] pc;   // Nibble address

   always_comb begin
      case (ctrl.op)
         up_pkg::DP_ADD:    result = r1 + r2;
         up_pkg::DP_SUB:    result = r1 - r2;
         up_pkg::DP_MUL:    result = r1 * r2;
         up_pkg::DP_DIV:    result = (r2 == 8'h00) ? 8'hFF : r1 / r2;
         up_pkg::DP_X01:    result = r0 ^ r1;
         up_pkg::DP_X12:    result = r1 ^ r2;
         up_pkg::DP_X23:    result = r2 ^ r3;
         up_pkg::DP_XPC2:   result = pc ^ r2;
         up_pkg::DP_R3:     result = r3;
         up_pkg::DP_INC:    result = r0 + 8'h01;
         up_pkg::DP_NAND:   result = ~(r1 & r2);
         up_pkg::DP_SP:     result = sp;
         up_pkg::DP_SP1:    result = sp + 8'h01;
         up_pkg::DP_SPINC:  result = sp + 8'h01;
         up_pkg::DP_SPDEC:  result = sp - 8'h01;
         up_pkg::DP_PCADDR: result = (pc >> 1) & 8'h7F;
         up_pkg::DP_PCINC:  result = pc + 8'h01;
         default:           result = data_in;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         z  <= 1'b0;
         pc <= 8'h00;
         sp <= SP_RESET;
         ir <= up_pkg::OP_ADD;
         r0 <= 8'h00;
         r1 <= 8'h0A;
         r2 <= 8'h01;
         r3 <= 8'h81;
      end else begin
         if (ctrl.z_we) begin
            z <= (result == 8'h00);
         end
         if (ctrl.ir_we) begin
            if (pc[0]) begin
               ir <= up_pkg::opcode_t'(data_in[3:0]);
            end else begin
               ir <= up_pkg::opcode_t'(data_in[7:4]);   // High nibble first
            end
         end
         if (ctrl.sp_we) begin
            sp <= result;
         end
         if (ctrl.pc_we) begin
            pc <= result;
         end
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel)
               up_pkg::SEL_I0: r0 <= data_in;
               up_pkg::SEL_I1: r1 <= data_in;
               up_pkg::SEL_I2: r2 <= data_in;
               up_pkg::SEL_I3: r3 <= data_in;
               up_pkg::SEL_O0: r0 <= result;
               up_pkg::SEL_O1: r1 <= result;
               up_pkg::SEL_O2: r2 <= result;
               up_pkg::SEL_O3: r3 <= result;
            endcase
         end
      end
   end

endmodule

//--- hdl/up_pkg.sv
package up_pkg;

   // Two opcodes per code byte, high nibble first
   typedef enum logic [3:0] {
      OP_ADD    = 4'h0,
      OP_SUB    = 4'h1,
      OP_MUL    = 4'h2,
      OP_DIV    = 4'h3,
      OP_SWP01  = 4'h4,
      OP_SWP12  = 4'h5,
      OP_SWP23  = 4'h6,
      OP_SWPPC2 = 4'h7,
      OP_LD     = 4'h8,
      OP_ST     = 4'h9,
      OP_INC    = 4'hA,
      OP_NAND   = 4'hB,
      OP_PUSH   = 4'hC,
      OP_POP    = 4'hD,
      OP_BEQZ   = 4'hE,
      OP_HALT   = 4'hF
   } opcode_t;

   typedef enum logic [4:0] {
      DP_ADD    = 5'b00000,
      DP_SUB    = 5'b00001,
      DP_MUL    = 5'b00010,
      DP_DIV    = 5'b00011,
      DP_X01    = 5'b00100,   // XOR steps of the swaps
      DP_X12    = 5'b00101,
      DP_X23    = 5'b00110,
      DP_XPC2   = 5'b00111,
      DP_R3     = 5'b01000,
      DP_INC    = 5'b01010,
      DP_NAND   = 5'b01011,
      DP_SP     = 5'b01100,
      DP_SP1    = 5'b01101,   // Pop address
      DP_PASS   = 5'b11001,
      DP_SPINC  = 5'b11010,
      DP_SPDEC  = 5'b11011,
      DP_PCADDR = 5'b11101,   // Byte address of current nibble
      DP_PCINC  = 5'b11111
   } dp_op_t;

   typedef enum logic [2:0] {
      SEL_I0 = 3'b000,
      SEL_I1 = 3'b001,
      SEL_I2 = 3'b010,
      SEL_I3 = 3'b011,
      SEL_O0 = 3'b100,
      SEL_O1 = 3'b101,
      SEL_O2 = 3'b110,
      SEL_O3 = 3'b111
   } rb_sel_t;

   typedef struct packed {
      dp_op_t  op;
      logic    ir_we;
      logic    pc_we;
      rb_sel_t rb_sel;
      logic    rb_we;
      logic    sp_we;
      logic    z_we;
   } dp_ctrl_t;

   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] wdata;
      logic       we;
   } mem_req_t;

endpackage

//--- hdl/up_top.sv
`timescale 1ns/1ps

module up_top #(
   parameter logic [7:0] SP_RESET = 8'hFF
) (
   input  logic             clk,
   input  logic             nRst,
   output logic             req,
   input  logic             ack,
   output up_pkg::mem_req_t bus,
   input  logic [7:0]       rdata,
   output logic             halted
);

   up_pkg::dp_ctrl_t ctrl;
   up_pkg::opcode_t  ir;
   up_pkg::mem_req_t mreq;
   logic [7:0]       result;
   logic [7:0]       r0;
   logic [7:0]       rd_data;
   logic             z;
   logic             start;
   logic             done;

   up_datapath #(
      .SP_RESET(SP_RESET)
   ) u_datapath (
      .clk    (clk),
      .nRst   (nRst),
      .ctrl   (ctrl),
      .data_in(rd_data),   // Bus read data feeds ir and registers
      .result (result),
      .r0     (r0),
      .ir     (ir),
      .z      (z)
   );

   up_control u_control (
      .clk   (clk),
      .nRst  (nRst),
      .ir    (ir),
      .z     (z),
      .ctrl  (ctrl),
      .result(result),
      .r0    (r0),
      .start (start),
      .mreq  (mreq),
      .done  (done),
      .halted(halted)
   );

   up_bus_master u_bus_master (
      .clk    (clk),
      .nRst   (nRst),
      .start  (start),
      .mreq   (mreq),
      .done   (done),
      .rd_data(rd_data),
      .req    (req),
      .ack    (ack),
      .bus    (bus),
      .rdata  (rdata)
   );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   input  logic reset_req,
   output logic clk,
   output logic nRst
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   initial begin
      nRst = 1'b0;
      forever begin
         wait (!reset_req);
         repeat (2) @(posedge clk);
         #1 nRst = 1'b1;
         wait (reset_req);
         nRst = 1'b0;
      end
   end

endmodule

//--- verification/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
   input  logic             clk,
   input  logic             req,
   input  up_pkg::mem_req_t bus,
   output logic             ack,
   output logic [7:0]       rdata,
   input  logic             load_en,
   input  logic [7:0]       load_addr,
   input  logic [7:0]       load_data
);

   logic [7:0]  mem [0:255];
   int unsigned delay;

   initial begin
      ack   = 1'b0;
      rdata = 8'h00;
      delay = 0;
      forever begin
         @(posedge clk);
         if (load_en) begin
            mem[load_addr] = load_data;   // Loads only while the core is in reset
         end
         #1;
         if (req && !ack) begin
            if (delay == 0) begin
               if (bus.we) begin
                  mem[bus.addr] = bus.wdata;
               end else begin
                  rdata = mem[bus.addr];
               end
               ack   = 1'b1;
               delay = $urandom_range(0, 3);
            end else begin
               delay--;
            end
         end else if (!req && ack) begin
            if (delay == 0) begin
               ack   = 1'b0;   // Only after req has fallen
               delay = $urandom_range(0, 3);
            end else begin
               delay--;
            end
         end
      end
   end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;

   localparam logic [7:0] SP_RESET = 8'hFF;
   localparam int MODEL_STEPS = 2000;
   localparam int HALT_TIMEOUT = MODEL_STEPS * 32;   // Worst case cycles per instruction

   logic             clk;
   logic             nRst;
   logic             reset_req;
   logic             req;
   logic             ack;
   logic             halted;
   logic [7:0]       rdata;
   up_pkg::mem_req_t bus;
   logic             load_en;
   logic [7:0]       load_addr;
   logic [7:0]       load_data;

   logic [3:0] prog_q[$];   // Program as nibbles
   logic [7:0] image [0:255];
   logic [7:0] model_mem [0:255];

   tb_clock clk_i (.reset_req(reset_req), .clk(clk), .nRst(nRst));

   tb_memory mem_i (
      .clk(clk), .req(req), .bus(bus), .ack(ack), .rdata(rdata),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
   );

   up_top #(.SP_RESET(SP_RESET)) uut (
      .clk(clk), .nRst(nRst), .req(req), .ack(ack),
      .bus(bus), .rdata(rdata), .halted(halted)
   );

   // Instruction-set model on model_mem, returns 1 when HALT is reached
   function automatic bit run_model(input int max_steps);
      logic [7:0] r0;
      logic [7:0] r1;
      logic [7:0] r2;
      logic [7:0] r3;
      logic [7:0] sp;
      logic [7:0] pc;
      logic [7:0] code;
      logic [7:0] tmp;
      logic [3:0] op;
      logic       z;
      int         step_n;
      r0 = 8'h00;
      r1 = 8'h0A;
      r2 = 8'h01;
      r3 = 8'h81;
      sp = SP_RESET;
      pc = 8'h00;
      z  = 1'b0;
      for (step_n = 0; step_n < max_steps; step_n++) begin
         code = model_mem[{1'b0, pc[7:1]}];
         op   = pc[0] ? code[3:0] : code[7:4];
         pc   = pc + 8'h01;
         case (op)
            up_pkg::OP_ADD:  r0 = r1 + r2;
            up_pkg::OP_SUB:  r0 = r1 - r2;
            up_pkg::OP_MUL:  r0 = r1 * r2;
            up_pkg::OP_DIV:  r0 = (r2 == 8'h00) ? 8'hFF : r1 / r2;
            up_pkg::OP_SWP01: begin
               tmp = r0;
               r0  = r1;
               r1  = tmp;
            end
            up_pkg::OP_SWP12: begin
               tmp = r1;
               r1  = r2;
               r2  = tmp;
            end
            up_pkg::OP_SWP23: begin
               tmp = r2;
               r2  = r3;
               r3  = tmp;
            end
            up_pkg::OP_SWPPC2: begin
               tmp = pc;
               pc  = r2;
               r2  = tmp;
            end
            up_pkg::OP_LD:   r0 = model_mem[r3];
            up_pkg::OP_ST:   model_mem[r3] = r0;
            up_pkg::OP_INC:  r0 = r0 + 8'h01;
            up_pkg::OP_NAND: r0 = ~(r1 & r2);
            up_pkg::OP_PUSH: begin
               model_mem[sp] = r0;
               sp            = sp - 8'h01;
            end
            up_pkg::OP_POP: begin
               sp = sp + 8'h01;
               r0 = model_mem[sp];
            end
            up_pkg::OP_BEQZ: if (z) pc = pc + 8'h01;
            default:         return 1'b1;
         endcase
         if (op inside {up_pkg::OP_ADD, up_pkg::OP_SUB, up_pkg::OP_MUL,
                        up_pkg::OP_DIV, up_pkg::OP_INC, up_pkg::OP_NAND}) begin
            z = (r0 == 8'h00);
         end
      end
      return 1'b0;
   endfunction

   function automatic void parse_program(input string text);
      logic [7:0] c;
      int         i;
      prog_q.delete();
      for (i = 0; i < text.len(); i++) begin
         c = text.getc(i);
         if (c >= 8'h30 && c <= 8'h39) prog_q.push_back(c[3:0]);
         else if (c >= 8'h41 && c <= 8'h46) prog_q.push_back(c[3:0] + 4'd9);
      end
   endfunction

   // Fill pattern everywhere, then code nibbles from byte 0, high nibble first
   function automatic void build_image();
      int a;
      int k;
      for (a = 0; a < 256; a++) image[a] = 8'(a * 59 + 7);
      for (k = 0; k < prog_q.size(); k++) begin
         if (k % 2 == 0) image[k / 2][7:4] = prog_q[k];
         else image[k / 2][3:0] = prog_q[k];
      end
      model_mem = image;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic run_test(input string name);
      int a;
      int cyc;
      build_image();
      if (!run_model(MODEL_STEPS)) fail_run({"Reference model never halted in ", name});
      reset_req = 1'b1;
      step();
      for (a = 0; a < 256; a++) begin
         load_en   = 1'b1;
         load_addr = 8'(a);
         load_data = image[a];
         step();
      end
      load_en   = 1'b0;
      reset_req = 1'b0;
      cyc = 0;
      while (!nRst && cyc < 10) begin
         step();
         cyc++;
      end
      if (!nRst) fail_run({"Reset was not released in ", name});
      cyc = 0;
      while (!halted && cyc < HALT_TIMEOUT) begin
         step();
         cyc++;
      end
      if (!halted) fail_run({"The core did not halt in ", name});
      for (a = 0; a < 256; a++) begin
         assert (mem_i.mem[a] === model_mem[a]) else begin
            $display("error %s addr %02h expected %02h actual %02h",
                     name, a, model_mem[a], mem_i.mem[a]);
            $display("Test failed");
            $fatal(1);
         end
      end
   endtask

   task automatic make_random_program();
      int len;
      int k;
      int tries;
      bit ok;
      ok    = 1'b0;
      tries = 0;
      while (!ok && tries < 50) begin
         prog_q.delete();
         len = $urandom_range(16, 48);
         for (k = 0; k < len; k++) prog_q.push_back(4'($urandom_range(0, 14)));
         prog_q.push_back(up_pkg::OP_HALT);
         build_image();
         ok = run_model(MODEL_STEPS);   // Keep only programs that end
         tries++;
      end
      if (!ok) fail_run("No terminating random program was found");
   endtask

   initial begin
      int n;
      void'($urandom(32'hbef3_8ea8));
      reset_req = 1'b1;
      load_en   = 1'b0;
      load_addr = 8'h00;
      load_data = 8'h00;
      parse_program("4 5 3 C 0 9 C 1 C 2 C 3 C F");
      run_test("arithmetic");
      parse_program("4 C 5 C 6 C A C B C 6 9 C F");
      run_test("swaps_logic");
      parse_program("8 A 9 C C D D 9 B 4 5 6 8 A 9 C D 9 F");
      run_test("memory_access");
      // Jump to nibble 0B and back to nibble 4 with both BEQZ outcomes
      parse_program("0 4 5 7 E C 3 E C 9 F C 7");
      run_test("control_flow");
      for (n = 0; n < 8; n++) begin
         make_random_program();
         run_test($sformatf("random_%0d", n));
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- verification/up_sva.sv
`timescale 1ns/1ps

module up_sva (
   input logic             clk,
   input logic             nRst,
   input logic             req,
   input logic             ack,
   input up_pkg::mem_req_t bus,
   input logic             halted
);

   req_held_until_ack: assert property (@(posedge clk) disable iff (!nRst)
      (req && !ack) |=> req)
      else $error("req dropped before ack rose");

   bus_stable: assert property (@(posedge clk) disable iff (!nRst)
      (req || ack) |=> $stable(bus))
      else $error("bus changed during a transfer");

   ack_after_req: assert property (@(posedge clk) disable iff (!nRst)
      $fell(ack) |-> !req)
      else $error("ack fell while req was high");

   reset_quiet: assert property (@(posedge clk)
      !nRst |-> (!req && !halted))
      else $error("req or halted high during reset");

endmodule

bind up_top up_sva sva_i (
   .clk   (clk),
   .nRst  (nRst),
   .req   (req),
   .ack   (ack),
   .bus   (bus),
   .halted(halted)
);

//--- vlog.f
hdl/up_pkg.sv
hdl/up_datapath.sv
hdl/up_control.sv
hdl/up_bus_master.sv
hdl/up_top.sv
verification/tb_clock.sv
verification/tb_memory.sv
verification/up_sva.sv
verification/tb_top.sv
